// File: common/conv_pkg.sv
`default_nettype none

package conv_pkg;

  localparam int IFMAP_WIDTH   = 16;  // ifmap and weight words
  localparam int OFMAP_WIDTH   = 32;
  localparam int ARRAY_HEIGHT  = 4;   // input channels, array rows
  localparam int ARRAY_WIDTH   = 4;   // output channels, array columns
  localparam int OUT_DEPTH     = 4;   // max outstanding result vectors
  localparam int ARRAY_LATENCY = ARRAY_HEIGHT + ARRAY_WIDTH - 1;

  typedef logic signed [IFMAP_WIDTH-1:0] ifmap_word_t;
  typedef logic signed [OFMAP_WIDTH-1:0] ofmap_word_t;

  typedef ifmap_word_t [ARRAY_HEIGHT-1:0] ifmap_vec_t;

  // row = input channel, column = output channel
  typedef ifmap_word_t [ARRAY_HEIGHT-1:0][ARRAY_WIDTH-1:0] weight_mat_t;

  typedef ofmap_word_t [ARRAY_WIDTH-1:0] ofmap_vec_t;

  typedef struct packed {
    logic       valid;
    ifmap_vec_t data;
  } ifmap_beat_t;

  typedef struct packed {
    logic       valid;
    ofmap_vec_t data;
  } result_t;

  typedef enum logic {
    SER_IDLE,
    SER_SEND
  } ser_state_e;

endpackage

`default_nettype wire

// File: systolic_array/skew_buffer.sv
`default_nettype none

module skew_buffer #(
  parameter int WIDTH      = 16,
  parameter bit DESCENDING = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [3:0][WIDTH-1:0] data_in,
  output logic [3:0][WIDTH-1:0] data_out
);

  for (genvar i = 0; i < 4; i++) begin : g_lane
    localparam int DEPTH = DESCENDING ? 3 - i : i;

    if (DEPTH == 0) begin : g_pass
      assign data_out[i] = data_in[i];
    end else begin : g_dly
      logic [DEPTH-1:0][WIDTH-1:0] sr;

      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          sr <= '0;
        end else begin
          sr[0] <= data_in[i];
          for (int k = 1; k < DEPTH; k++) begin
            sr[k] <= sr[k-1];
          end
        end
      end

      assign data_out[i] = sr[DEPTH-1];  // oldest stage
    end
  end

endmodule

`default_nettype wire

// File: systolic_array/sys_pe.sv
`default_nettype none

module sys_pe (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   weight_load,
  input  logic signed [conv_pkg::IFMAP_WIDTH-1:0] weight_in,
  input  logic signed [conv_pkg::IFMAP_WIDTH-1:0] ifmap_in,
  input  logic signed [conv_pkg::OFMAP_WIDTH-1:0] psum_in,
  output logic signed [conv_pkg::IFMAP_WIDTH-1:0] ifmap_out,
  output logic signed [conv_pkg::OFMAP_WIDTH-1:0] psum_out
);
  import conv_pkg::*;

  logic signed [IFMAP_WIDTH-1:0] weight;  // stationary

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      weight    <= '0;
      ifmap_out <= '0;
      psum_out  <= '0;
    end else begin
      if (weight_load) weight <= weight_in;
      psum_out  <= psum_in + ifmap_in * weight;  // wraps at 32 bits
      ifmap_out <= ifmap_in;
    end
  end

endmodule

`default_nettype wire

// File: systolic_array/systolic_array.sv
`default_nettype none

module systolic_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  conv_pkg::ifmap_beat_t vec,
  input  conv_pkg::weight_mat_t weights,
  input  logic                  weight_load,
  output conv_pkg::result_t     result
);
  import conv_pkg::*;

  ifmap_vec_t                   skewed;
  ofmap_vec_t                   bottom;
  ofmap_vec_t                   deskewed;
  ifmap_word_t                  ifmap_h [ARRAY_HEIGHT][ARRAY_WIDTH+1];
  ofmap_word_t                  psum_v  [ARRAY_HEIGHT+1][ARRAY_WIDTH];
  logic [ARRAY_LATENCY-1:0]     vld_pipe;

  // row r enters r cycles late
  skew_buffer #(.WIDTH(IFMAP_WIDTH), .DESCENDING(1'b0)) i_in_skew (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_in  (vec.data),
    .data_out (skewed)
  );

  for (genvar r = 0; r < ARRAY_HEIGHT; r++) begin : g_row
    assign ifmap_h[r][0] = skewed[r];
    for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_col
      sys_pe i_pe (
        .clk         (clk),
        .rst_n       (rst_n),
        .weight_load (weight_load),
        .weight_in   (weights[r][c]),
        .ifmap_in    (ifmap_h[r][c]),
        .psum_in     (psum_v[r][c]),
        .ifmap_out   (ifmap_h[r][c+1]),
        .psum_out    (psum_v[r+1][c])
      );
    end
  end

  for (genvar c = 0; c < ARRAY_WIDTH; c++) begin : g_edge
    assign psum_v[0][c] = '0;  // top row starts from zero
    assign bottom[c]    = psum_v[ARRAY_HEIGHT][c];
  end

  // column c waits 3-c cycles so all sums line up
  skew_buffer #(.WIDTH(OFMAP_WIDTH), .DESCENDING(1'b1)) i_out_deskew (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_in  (bottom),
    .data_out (deskewed)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe <= {vld_pipe[ARRAY_LATENCY-2:0], vec.valid};
    end
  end

  assign result.valid = vld_pipe[ARRAY_LATENCY-1];
  assign result.data  = deskewed;

  // swapping weights mid-flight would mix two matrices in one result
  a_no_load_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n)
    weight_load |-> (vld_pipe == '0)
  );

endmodule

`default_nettype wire

// File: verilog/ifmap_packer.sv
`default_nettype none

module ifmap_packer (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0] ifmap_dat,
  input  logic                            ifmap_vld,
  input  logic                            credit_ok,
  input  logic                            weights_partial,
  output logic                            ifmap_rdy,
  output conv_pkg::ifmap_beat_t           vec
);
  import conv_pkg::*;

  logic [$clog2(ARRAY_HEIGHT)-1:0] lane_cnt;
  ifmap_vec_t                      lanes;    // filled lane by lane
  logic                            vec_vld;
  logic                            accept;

  // hold off while a weight set is half loaded
  assign ifmap_rdy = credit_ok && !weights_partial;
  assign accept    = ifmap_vld && ifmap_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt <= '0;
      vec_vld  <= 1'b0;
    end else begin
      vec_vld <= accept && (lane_cnt == ARRAY_HEIGHT - 1);
      if (accept) lane_cnt <= lane_cnt + 1'b1;  // wraps after lane 3
    end
  end

  always_ff @(posedge clk) begin
    if (accept) lanes[lane_cnt] <= ifmap_dat;
  end

  assign vec.valid = vec_vld;
  assign vec.data  = lanes;

endmodule

`default_nettype wire

// File: verilog/weight_loader.sv
`default_nettype none

module weight_loader (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0] weights_dat,
  input  logic                            weights_vld,
  input  logic                            core_idle,
  output logic                            weights_rdy,
  output logic                            weights_partial,
  output logic                            weight_load,
  output conv_pkg::weight_mat_t           weights
);
  import conv_pkg::*;

  localparam int NUM_WEIGHTS = ARRAY_HEIGHT * ARRAY_WIDTH;

  logic [$clog2(NUM_WEIGHTS)-1:0] idx;
  logic                           accept;

  assign weights_rdy     = core_idle;
  assign accept          = weights_vld && weights_rdy;
  assign weights_partial = (idx != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx         <= '0;
      weight_load <= 1'b0;
    end else begin
      weight_load <= accept && (idx == NUM_WEIGHTS - 1);
      if (accept) idx <= idx + 1'b1;
    end
  end

  // row-major fill, upper index bits pick the row
  always_ff @(posedge clk) begin
    if (accept) weights[idx[3:2]][idx[1:0]] <= weights_dat;
  end

endmodule

`default_nettype wire

// File: verilog/ofmap_serializer.sv
`default_nettype none

module ofmap_serializer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             ofmap_rdy,
  input  logic                             vec_taken,
  input  conv_pkg::result_t                result,
  output logic                             ofmap_vld,
  output logic                             credit_ok,
  output logic                             core_idle,
  output logic [conv_pkg::OFMAP_WIDTH-1:0] ofmap_dat
);
  import conv_pkg::*;

  localparam int PTR_W = $clog2(OUT_DEPTH);
  localparam int CNT_W = $clog2(OUT_DEPTH + 1);

  ofmap_vec_t                      queue [OUT_DEPTH];
  logic [PTR_W-1:0]                wr_ptr;
  logic [PTR_W-1:0]                rd_ptr;
  logic [CNT_W-1:0]                q_cnt;     // vectors sitting in the queue
  logic [CNT_W-1:0]                out_cnt;   // in flight plus queued
  logic [$clog2(ARRAY_WIDTH)-1:0]  word_idx;
  ser_state_e                      state;
  logic                            push;
  logic                            last_word;

  assign push      = result.valid;
  assign last_word = (state == SER_SEND) && ofmap_rdy && (word_idx == ARRAY_WIDTH - 1);

  assign credit_ok = (out_cnt < OUT_DEPTH);
  assign core_idle = (out_cnt == '0);
  assign ofmap_vld = (state == SER_SEND);
  assign ofmap_dat = queue[rd_ptr][word_idx];

  always_ff @(posedge clk) begin
    if (push) queue[wr_ptr] <= result.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_cnt   <= '0;
      out_cnt <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (last_word) rd_ptr <= rd_ptr + 1'b1;
      case ({push, last_word})
        2'b10:   q_cnt <= q_cnt + 1'b1;
        2'b01:   q_cnt <= q_cnt - 1'b1;
        default: q_cnt <= q_cnt;
      endcase
      case ({vec_taken, last_word})
        2'b10:   out_cnt <= out_cnt + 1'b1;
        2'b01:   out_cnt <= out_cnt - 1'b1;
        default: out_cnt <= out_cnt;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= SER_IDLE;
      word_idx <= '0;
    end else begin
      case (state)
        SER_IDLE: begin
          word_idx <= '0;
          if (q_cnt != '0) state <= SER_SEND;
        end
        SER_SEND: begin
          if (ofmap_rdy) begin
            word_idx <= word_idx + 1'b1;  // back to 0 after channel 3
            // keep going if another vector is waiting or arrives now
            if (last_word && q_cnt == 1 && !push) state <= SER_IDLE;
          end
        end
        default: state <= SER_IDLE;
      endcase
    end
  end

  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    push |-> (q_cnt < OUT_DEPTH)
  );

  a_outstanding_bounded: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_cnt <= OUT_DEPTH
  );

endmodule

`default_nettype wire

// File: verilog/conv_core.sv
`default_nettype none

module conv_core (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0] ifmap_dat,
  input  logic                             ifmap_vld,
  output logic                             ifmap_rdy,
  input  logic [conv_pkg::IFMAP_WIDTH-1:0] weights_dat,
  input  logic                             weights_vld,
  output logic                             weights_rdy,
  output logic [conv_pkg::OFMAP_WIDTH-1:0] ofmap_dat,
  output logic                             ofmap_vld,
  input  logic                             ofmap_rdy
);
  import conv_pkg::*;

  ifmap_beat_t vec;
  weight_mat_t weights;
  result_t     result;
  logic        weight_load;
  logic        weights_partial;
  logic        credit_ok;
  logic        core_idle;

  ifmap_packer i_ifmap_packer (
    .clk             (clk),
    .rst_n           (rst_n),
    .ifmap_dat       (ifmap_dat),
    .ifmap_vld       (ifmap_vld),
    .credit_ok       (credit_ok),
    .weights_partial (weights_partial),
    .ifmap_rdy       (ifmap_rdy),
    .vec             (vec)
  );

  // weights only taken with nothing outstanding
  weight_loader i_weight_loader (
    .clk             (clk),
    .rst_n           (rst_n),
    .weights_dat     (weights_dat),
    .weights_vld     (weights_vld),
    .core_idle       (core_idle),
    .weights_rdy     (weights_rdy),
    .weights_partial (weights_partial),
    .weight_load     (weight_load),
    .weights         (weights)
  );

  systolic_array i_systolic_array (
    .clk         (clk),
    .rst_n       (rst_n),
    .vec         (vec),
    .weights     (weights),
    .weight_load (weight_load),
    .result      (result)
  );

  ofmap_serializer i_ofmap_serializer (
    .clk       (clk),
    .rst_n     (rst_n),
    .ofmap_rdy (ofmap_rdy),
    .vec_taken (vec.valid),  // credit counted per packed vector
    .result    (result),
    .ofmap_vld (ofmap_vld),
    .credit_ok (credit_ok),
    .core_idle (core_idle),
    .ofmap_dat (ofmap_dat)
  );

endmodule

`default_nettype wire

// File: verif/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: verif/conv_core_checker.sv
`default_nettype none

module conv_core_checker (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        ifmap_vld,
  input  logic        ifmap_rdy,
  input  logic        weights_rdy,
  input  logic        ofmap_vld,
  input  logic        ofmap_rdy,
  input  logic [31:0] ofmap_dat,
  output int          errors,
  output int          pending
);
  import conv_pkg::*;

  logic [31:0] exp_q [$];
  int          test_errs;
  int          tests_done;
  int          tests_failed;
  int          words_checked;
  int          in_words;
  int          accepted;      // vectors whose fourth word was taken
  int          sent_words;
  int          sent;          // vectors fully sent
  int          out_prev;
  int          out_prev2;
  logic        ifmap_rdy_s;
  logic        weights_rdy_s;
  logic        ofmap_vld_s;
  logic [31:0] ofmap_dat_s;

  initial begin
    errors        = 0;
    pending       = 0;
    test_errs     = 0;
    tests_done    = 0;
    tests_failed  = 0;
    words_checked = 0;
    in_words      = 0;
    accepted      = 0;
    sent_words    = 0;
    sent          = 0;
    out_prev      = 0;
    out_prev2     = 0;
  end

  task automatic note_error();
    errors    = errors + 1;
    test_errs = test_errs + 1;
  endtask

  task automatic expect_word(input logic [31:0] w);
    exp_q.push_back(w);
    pending = pending + 1;
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("[FAIL] %0t %s expected %0b actual %0b", $time, name, exp, act);
      note_error();
    end
  endtask

  // called mid-cycle, outputs are settled
  task automatic check_reset_state();
    check_bit("ofmap_vld", 1'b0, ofmap_vld);
    check_bit("ifmap_rdy", 1'b1, ifmap_rdy);
    check_bit("weights_rdy", 1'b1, weights_rdy);
  endtask

  task automatic end_test(input string name);
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, test_errs);
      tests_failed = tests_failed + 1;
    end
    tests_done = tests_done + 1;
    test_errs  = 0;
  endtask

  task automatic summary();
    $display("tests %0d, failed %0d, words checked %0d, errors %0d",
             tests_done, tests_failed, words_checked, errors);
  endtask

  // dut outputs only move on the rising edge
  always @(negedge clk) begin
    ifmap_rdy_s   = ifmap_rdy;
    weights_rdy_s = weights_rdy;
    ofmap_vld_s   = ofmap_vld;
    ofmap_dat_s   = ofmap_dat;
  end

  always @(posedge clk) begin : watch
    logic [31:0] exp;
    int          outstanding;
    if (rst_n) begin
      if (ofmap_vld_s && ofmap_rdy) begin
        if (exp_q.size() == 0) begin
          $display("%0t: ofmap word %08h came out with no result expected", $time, ofmap_dat_s);
          note_error();
        end else begin
          exp           = exp_q.pop_front();
          pending       = pending - 1;
          words_checked = words_checked + 1;
          if (exp !== ofmap_dat_s) begin
            $display("[FAIL] %0t ofmap_dat expected %08h actual %08h", $time, exp, ofmap_dat_s);
            note_error();
          end
        end
        sent_words = sent_words + 1;
        if (sent_words % ARRAY_WIDTH == 0) sent = sent + 1;
      end
      if (ifmap_vld && ifmap_rdy_s) begin
        in_words = in_words + 1;
        if (in_words % ARRAY_HEIGHT == 0) accepted = accepted + 1;
      end
      // core_idle trails the port by one cycle
      if (weights_rdy_s && out_prev > 0 && out_prev2 > 0) begin
        $display("%0t: weights_rdy was high while vectors were outstanding", $time);
        note_error();
      end
      outstanding = accepted - sent;
      if (outstanding > OUT_DEPTH) begin
        $display("%0t: %0d vectors outstanding, more than the queue holds", $time, outstanding);
        note_error();
      end
      out_prev2 = out_prev;
      out_prev  = outstanding;
    end
  end

endmodule

`default_nettype wire

// File: verif/conv_core_tb.sv
`default_nettype none

module conv_core_tb;
  import conv_pkg::*;

  localparam string STIM_FILE = "verif/conv_core_stimulus.txt";

  logic        clk;
  logic        rst_n;
  logic [15:0] ifmap_dat;
  logic        ifmap_vld;
  logic        ifmap_rdy;
  logic [15:0] weights_dat;
  logic        weights_vld;
  logic        weights_rdy;
  logic [31:0] ofmap_dat;
  logic        ofmap_vld;
  logic        ofmap_rdy;
  int          errors;
  int          pending;
  int          cycles;
  int          cycle_limit;
  int          low_pct;      // percent of cycles with ofmap_rdy low
  string       cur_test;

  tb_clock #(.PERIOD(20)) i_tb_clock (.clk(clk));

  conv_core i_conv_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .ifmap_dat   (ifmap_dat),
    .ifmap_vld   (ifmap_vld),
    .ifmap_rdy   (ifmap_rdy),
    .weights_dat (weights_dat),
    .weights_vld (weights_vld),
    .weights_rdy (weights_rdy),
    .ofmap_dat   (ofmap_dat),
    .ofmap_vld   (ofmap_vld),
    .ofmap_rdy   (ofmap_rdy)
  );

  conv_core_checker i_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .ifmap_vld   (ifmap_vld),
    .ifmap_rdy   (ifmap_rdy),
    .weights_rdy (weights_rdy),
    .ofmap_vld   (ofmap_vld),
    .ofmap_rdy   (ofmap_rdy),
    .ofmap_dat   (ofmap_dat),
    .errors      (errors),
    .pending     (pending)
  );

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, test %s was still running", cycles, cur_test);
      $display("Result: FAILED");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (rst_n) ofmap_rdy = (int'($urandom % 100) >= low_pct);
  end

  // all send tasks start and end on a falling edge
  task automatic send_ifmap(input int v);
    ifmap_dat = 16'(v);
    ifmap_vld = 1'b1;
    while (!ifmap_rdy) @(negedge clk);
    @(negedge clk);
    ifmap_vld = 1'b0;
  endtask

  task automatic send_weight(input int v);
    weights_dat = 16'(v);
    weights_vld = 1'b1;
    while (!weights_rdy) @(negedge clk);
    @(negedge clk);
    weights_vld = 1'b0;
  endtask

  task automatic wait_drained();
    while (pending != 0 || !weights_rdy) @(negedge clk);
  endtask

  task automatic count_records(output int nx, output int nw, output bit opened);
    int    fd;
    string line;
    string tok;
    nx = 0;
    nw = 0;
    fd = $fopen(STIM_FILE, "r");
    opened = (fd != 0);
    if (!opened) begin
      $display("cannot open %s", STIM_FILE);
    end else begin
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%s", tok) == 1) begin
          if (tok == "X") nx = nx + 1;
          if (tok == "W") nw = nw + 1;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_stimulus();
    int    fd;
    int    v [16];
    string line;
    string tok;
    fd = $fopen(STIM_FILE, "r");
    while ($fgets(line, fd) > 0) begin
      if ($sscanf(line, "%s", tok) != 1) continue;
      case (tok)
        "T": void'($sscanf(line, "%s %s", tok, cur_test));
        "B": void'($sscanf(line, "%s %d", tok, low_pct));
        "W": begin
          void'($sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", tok,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]));
          wait_drained();
          for (int i = 0; i < 16; i++) send_weight(v[i]);
        end
        "X": begin
          void'($sscanf(line, "%s %d %d %d %d %d %d %d %d", tok,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]));
          for (int i = 4; i < 8; i++) i_chk.expect_word(32'(v[i]));
          for (int i = 0; i < 4; i++) send_ifmap(v[i]);
        end
        "E": begin
          wait_drained();
          i_chk.end_test(cur_test);
        end
        default: ;  // comment line
      endcase
    end
    $fclose(fd);
  endtask

  initial begin : main
    int nx;
    int nw;
    bit opened;
    rst_n       = 1'b0;
    ifmap_dat   = '0;
    ifmap_vld   = 1'b0;
    weights_dat = '0;
    weights_vld = 1'b0;
    ofmap_rdy   = 1'b1;
    low_pct     = 0;
    cycles      = 0;
    cycle_limit = 1000;
    cur_test    = "setup";
    void'($urandom(32'hcebbcdf9));
    count_records(nx, nw, opened);
    if (opened) begin
      cycle_limit = 40 * nx + 30 * nw + 200;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      cur_test = "reset_idle";
      i_chk.check_reset_state();
      i_chk.end_test(cur_test);
      run_stimulus();
      wait_drained();
      i_chk.summary();
    end
    if (opened && errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/conv_core_stimulus.txt
# T name | B percent of cycles with ofmap_rdy low | W w0..w15 row-major, word 4r+c is w[r][c]
# X x0 x1 x2 x3 then expected y0 y1 y2 y3 (channel 0 first) | E ends the test
T single_vector
B 0
W 1 2 3 4 -1 0 5 -2 10 -10 0 7 0 1 -3 100
X 3 -4 2 5 27 -9 -26 534
X 0 0 0 0 0 0 0 0
X 1 1 1 1 10 -7 5 109
E
T sign_wrap
B 0
W -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768 -32768
X -32768 -32768 -32768 -32768 0 0 0 0
X -32768 -32768 -32768 0 -1073741824 -1073741824 -1073741824 -1073741824
X 32767 32767 32767 32767 131072 131072 131072 131072
X 1 1 1 1 -131072 -131072 -131072 -131072
E
T back_to_back
B 0
W 1 0 0 0 0 1 0 0 0 0 1 0 0 0 0 1
X 1 2 3 4 1 2 3 4
X -5 6 -7 8 -5 6 -7 8
X 100 200 300 400 100 200 300 400
X 32767 -32768 0 -1 32767 -32768 0 -1
X 9 8 7 6 9 8 7 6
X 11 -12 13 -14 11 -12 13 -14
E
T backpressure
B 80
X 21 22 23 24 21 22 23 24
X -1 -2 -3 -4 -1 -2 -3 -4
X 500 -600 700 -800 500 -600 700 -800
X 31 32 33 34 31 32 33 34
X 41 42 43 44 41 42 43 44
X -51 52 -53 54 -51 52 -53 54
E
T weight_reload
B 0
W 1 2 3 4 -1 0 5 -2 10 -10 0 7 0 1 -3 100
X 3 -4 2 5 27 -9 -26 534
X 1 1 1 1 10 -7 5 109
E

// File: compile.f
common/conv_pkg.sv
systolic_array/skew_buffer.sv
systolic_array/sys_pe.sv
systolic_array/systolic_array.sv
verilog/ifmap_packer.sv
verilog/weight_loader.sv
verilog/ofmap_serializer.sv
verilog/conv_core.sv
verif/tb_clock.sv
verif/conv_core_checker.sv
verif/conv_core_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f compile.f --top-module conv_core_tb -o conv_core_sim \
  && ./obj_dir/conv_core_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation ok" \
  || { echo "simulation not ok"; exit 1; }
